/* source/dii_pkg.sv */
package dii_pkg;

   localparam int FLIT_WIDTH = 16;
   localparam int HDR_FLITS  = 3;                    // Destination, source, type

   localparam logic [9:0] MOD_ID  = 10'h005;
   localparam logic [9:0] HOST_ID = 10'h000;

   // Identification registers 0x0000 and 0x0001
   localparam logic [15:0] MODID_VALUE      = 16'h0003;
   localparam logic [15:0] MODVERSION_VALUE = 16'h0000;

   localparam logic [1:0] TYPE_REG   = 2'b00;        // Type flit bits 15:14
   localparam logic [1:0] TYPE_EVENT = 2'b01;

   localparam logic [3:0] SUB_REG_READ      = 4'h0;  // Type flit bits 13:10
   localparam logic [3:0] SUB_REG_READ_RESP = 4'h8;
   localparam logic [3:0] SUB_REG_ERR       = 4'hc;

endpackage

/* source/mam_pkg.sv */
package mam_pkg;

   localparam int DATA_WIDTH = 32;
   localparam int ADDR_WIDTH = 32;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;
   localparam int WORD_FLITS = DATA_WIDTH / 16;
   localparam int ADDR_FLITS = ADDR_WIDTH / 16;
   localparam int WORD_CNT_W = $clog2(WORD_FLITS);

   localparam int MAX_PKT_LEN = 8;                   // Data flits per read packet
   localparam int PKT_CNT_W   = $clog2(MAX_PKT_LEN);

   localparam int REGIONS = 1;
   localparam logic [ADDR_WIDTH-1:0] BASE_ADDR0 = 32'h0000_1000;
   localparam int MEM_SIZE0  = 1024;                 // Bytes
   localparam int MEM_WORDS  = MEM_SIZE0 / STRB_WIDTH;
   localparam int WORD_IDX_W = $clog2(MEM_WORDS);

   // Command flit layout
   localparam int CMD_RW_BIT    = 15;                // 1 is write
   localparam int CMD_BURST_BIT = 14;
   localparam int BEAT_WIDTH    = 14;

endpackage

/* source/flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   payload_t                     mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic                         push;
   logic                         pop;

   assign in_ready  = (count < DEPTH);
   assign out_valid = (count != 0);
   assign out_data  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                               // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

endmodule

/* source/osd_regaccess.sv */
`timescale 1ns/1ps

module osd_regaccess
   import dii_pkg::*, mam_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [FLIT_WIDTH-1:0] in_data,
   input  logic                  in_last,
   input  logic                  in_valid,
   output logic                  in_ready,
   output logic [FLIT_WIDTH-1:0] ev_data,
   output logic                  ev_last,
   output logic                  ev_valid,
   input  logic                  ev_ready,
   input  logic [FLIT_WIDTH-1:0] resp_data,
   input  logic                  resp_last,
   input  logic                  resp_valid,
   output logic                  resp_ready,
   output logic [FLIT_WIDTH-1:0] out_data,
   output logic                  out_last,
   output logic                  out_valid,
   input  logic                  out_ready
);

   typedef enum logic [2:0] {
      R_HDR, R_EV_HDR, R_EV_BODY, R_REG_ADDR, R_REG_DRAIN, R_REG_RESP
   } rstate_t;

   rstate_t               state;
   logic [1:0]            cnt;
   logic [FLIT_WIDTH-1:0] hdr [HDR_FLITS];
   logic [FLIT_WIDTH-1:0] reg_addr;
   logic                  reg_read;
   logic [FLIT_WIDTH-1:0] reg_rdata;
   logic                  reg_err;
   logic [FLIT_WIDTH-1:0] loc_data;
   logic                  loc_last;
   logic                  loc_valid;
   logic                  loc_ready;
   logic                  lock;
   logic                  lock_mam;
   logic                  use_mam;

   always_comb begin
      in_ready = 1'b0;
      ev_valid = 1'b0;
      ev_data  = '0;
      ev_last  = 1'b0;
      case (state)
         R_HDR, R_REG_ADDR, R_REG_DRAIN: in_ready = 1'b1;
         R_EV_HDR: begin                             // Replay buffered header
            ev_valid = 1'b1;
            ev_data  = hdr[cnt];
         end
         R_EV_BODY: begin
            ev_valid = in_valid;
            ev_data  = in_data;
            ev_last  = in_last;
            in_ready = ev_ready;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= R_HDR;
         cnt   <= '0;
      end else begin
         case (state)
            R_HDR: if (in_valid) begin
               cnt <= cnt + 1'b1;
               if (cnt == 2'(HDR_FLITS - 1)) begin
                  cnt <= '0;
                  if (in_data[15:14] == TYPE_EVENT) state <= R_EV_HDR;
                  else if (in_last) state <= R_REG_RESP;    // No address, error
                  else state <= R_REG_ADDR;
               end
            end
            R_EV_HDR: if (ev_ready) begin
               cnt <= cnt + 1'b1;
               if (cnt == 2'(HDR_FLITS - 1)) begin
                  cnt   <= '0;
                  state <= R_EV_BODY;
               end
            end
            R_EV_BODY: if (in_valid && ev_ready && in_last) state <= R_HDR;
            R_REG_ADDR: if (in_valid) state <= in_last ? R_REG_RESP : R_REG_DRAIN;
            R_REG_DRAIN: if (in_valid && in_last) state <= R_REG_RESP;
            R_REG_RESP: if (loc_ready) begin
               cnt <= cnt + 1'b1;                    // Wraps to 0 after last
               if (loc_last) state <= R_HDR;
            end
            default: state <= R_HDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == R_HDR && in_valid) begin
         hdr[cnt] <= in_data;
         reg_read <= (in_data[15:14] == TYPE_REG) && (in_data[13:10] == SUB_REG_READ)
                     && !in_last;
      end
      if (state == R_REG_ADDR && in_valid) begin
         reg_addr <= in_data;
      end
   end

   always_comb begin
      reg_err   = 1'b0;
      reg_rdata = '0;
      case (reg_addr) inside
         16'h0000: reg_rdata = MODID_VALUE;
         16'h0001: reg_rdata = MODVERSION_VALUE;
         16'h0200: reg_rdata = 16'(DATA_WIDTH);
         16'h0201: reg_rdata = 16'(ADDR_WIDTH);
         16'h0202: reg_rdata = 16'(REGIONS);
         [16'h0280:16'h0283]: reg_rdata = 16'(64'(BASE_ADDR0) >> (16 * reg_addr[1:0]));
         [16'h0284:16'h0287]: reg_rdata = 16'(64'(MEM_SIZE0) >> (16 * reg_addr[1:0]));
         default: reg_err = 1'b1;
      endcase
      if (!reg_read) reg_err = 1'b1;                // Writes always fail
      if (reg_err) reg_rdata = '0;
   end

   assign loc_valid = (state == R_REG_RESP);
   assign loc_last  = (cnt == 2'd3);

   always_comb begin
      case (cnt)
         2'd0:    loc_data = hdr[1];                 // Back to requester
         2'd1:    loc_data = FLIT_WIDTH'(MOD_ID);
         2'd2:    loc_data = {TYPE_REG, reg_err ? SUB_REG_ERR : SUB_REG_READ_RESP, 10'h000};
         default: loc_data = reg_rdata;
      endcase
   end

   // Output arbiter, held from first offer until last flit leaves
   assign use_mam    = lock ? lock_mam : !loc_valid;
   assign out_valid  = use_mam ? resp_valid : loc_valid;
   assign out_data   = use_mam ? resp_data : loc_data;
   assign out_last   = use_mam ? resp_last : loc_last;
   assign resp_ready = use_mam && out_ready;
   assign loc_ready  = !use_mam && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         lock     <= 1'b0;
         lock_mam <= 1'b0;
      end else if (out_valid) begin
         lock     <= !(out_ready && out_last);
         lock_mam <= use_mam;
      end
   end

endmodule

/* source/osd_mam.sv */
`timescale 1ns/1ps

module osd_mam
   import dii_pkg::*, mam_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [FLIT_WIDTH-1:0] ev_data,
   input  logic                  ev_last,
   input  logic                  ev_valid,
   output logic                  ev_ready,
   output logic [FLIT_WIDTH-1:0] resp_data,
   output logic                  resp_last,
   output logic                  resp_valid,
   input  logic                  resp_ready,
   output logic                  req_valid,
   output logic                  req_rw,
   output logic [ADDR_WIDTH-1:0] req_addr,
   output logic                  req_burst,
   output logic [BEAT_WIDTH-1:0] req_beats,
   input  logic                  req_ready,
   output logic                  write_valid,
   output logic [DATA_WIDTH-1:0] write_data,
   output logic [STRB_WIDTH-1:0] write_strb,
   input  logic                  write_ready,
   input  logic                  read_valid,
   input  logic [DATA_WIDTH-1:0] read_data,
   output logic                  read_ready
);

   typedef enum logic [3:0] {
      S_HDR, S_CMD, S_ADDR, S_REQUEST, S_WR_HDR, S_WRITE, S_WRITE_WAIT, S_RD_HDR, S_READ
   } state_t;

   state_t                state, nxt_state;
   logic [PKT_CNT_W-1:0]  counter, nxt_counter;     // Flits within a packet
   logic [WORD_CNT_W-1:0] wcounter, nxt_wcounter;   // Flits within a word
   logic                  in_packet, nxt_in_packet;
   logic                  is_last_flit, nxt_is_last_flit;
   logic                  nxt_req_rw;
   logic                  nxt_req_burst;
   logic [BEAT_WIDTH-1:0] nxt_req_beats;
   logic [ADDR_WIDTH-1:0] nxt_req_addr;
   logic [DATA_WIDTH-1:0] nxt_write_data;
   logic [STRB_WIDTH-1:0] nxt_write_strb;
   logic                  word_end;

   assign word_end = (wcounter == WORD_CNT_W'(WORD_FLITS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= S_HDR;
         counter      <= '0;
         wcounter     <= '0;
         in_packet    <= 1'b0;
         is_last_flit <= 1'b0;
      end else begin
         state        <= nxt_state;
         counter      <= nxt_counter;
         wcounter     <= nxt_wcounter;
         in_packet    <= nxt_in_packet;
         is_last_flit <= nxt_is_last_flit;
      end
      req_rw     <= nxt_req_rw;
      req_burst  <= nxt_req_burst;
      req_beats  <= nxt_req_beats;
      req_addr   <= nxt_req_addr;
      write_data <= nxt_write_data;
      write_strb <= nxt_write_strb;
   end

   always_comb begin
      nxt_state        = state;
      nxt_counter      = counter;
      nxt_wcounter     = wcounter;
      nxt_in_packet    = in_packet;
      nxt_is_last_flit = is_last_flit;
      nxt_req_rw       = req_rw;
      nxt_req_burst    = req_burst;
      nxt_req_beats    = req_beats;
      nxt_req_addr     = req_addr;
      nxt_write_data   = write_data;
      nxt_write_strb   = write_strb;
      ev_ready    = 1'b0;
      resp_valid  = 1'b0;
      resp_data   = '0;
      resp_last   = 1'b0;
      req_valid   = 1'b0;
      write_valid = 1'b0;
      read_ready  = 1'b0;

      case (state)
         S_HDR, S_WR_HDR: begin                      // Header skipped
            ev_ready = 1'b1;
            if (ev_valid) begin
               nxt_counter = counter + 1'b1;
               if (counter == PKT_CNT_W'(HDR_FLITS - 1)) begin
                  nxt_counter = '0;
                  nxt_state   = (state == S_HDR) ? S_CMD : S_WRITE;
               end
            end
         end
         S_CMD: begin
            ev_ready = 1'b1;
            if (ev_valid) begin
               nxt_req_rw     = ev_data[CMD_RW_BIT];
               nxt_req_burst  = ev_data[CMD_BURST_BIT];
               nxt_req_beats  = ev_data[CMD_BURST_BIT] ? ev_data[BEAT_WIDTH-1:0]
                                                      : BEAT_WIDTH'(1);
               nxt_write_strb = ev_data[CMD_BURST_BIT] ? '1 : ev_data[STRB_WIDTH-1:0];
               nxt_state      = S_ADDR;
            end
         end
         S_ADDR: begin
            ev_ready = 1'b1;
            if (ev_valid) begin
               nxt_req_addr[(ADDR_FLITS - counter) * FLIT_WIDTH - 1 -: FLIT_WIDTH] = ev_data;
               nxt_counter = counter + 1'b1;
               if (counter == PKT_CNT_W'(ADDR_FLITS - 1)) begin
                  nxt_is_last_flit = ev_last;
                  nxt_state        = S_REQUEST;
               end
            end
         end
         S_REQUEST: begin
            req_valid = 1'b1;
            if (req_ready) begin
               nxt_counter  = '0;
               nxt_wcounter = '0;
               if (!req_rw) nxt_state = S_RD_HDR;
               else if (is_last_flit) nxt_state = S_WR_HDR;  // Data in next packet
               else nxt_state = S_WRITE;
            end
         end
         S_WRITE: begin
            ev_ready = 1'b1;
            if (ev_valid) begin
               nxt_write_data[(WORD_FLITS - wcounter) * FLIT_WIDTH - 1 -: FLIT_WIDTH] = ev_data;
               nxt_wcounter = wcounter + 1'b1;
               if (word_end) begin
                  nxt_wcounter  = '0;
                  nxt_in_packet = !ev_last;
                  nxt_state     = S_WRITE_WAIT;
               end else if (ev_last) begin
                  nxt_state = S_WR_HDR;              // Word split over packets
               end
            end
         end
         S_WRITE_WAIT: begin
            write_valid = 1'b1;
            if (write_ready) begin
               nxt_req_beats = req_beats - 1'b1;
               if (req_beats == BEAT_WIDTH'(1)) nxt_state = S_HDR;
               else if (in_packet) nxt_state = S_WRITE;
               else nxt_state = S_WR_HDR;
            end
         end
         S_RD_HDR: begin
            resp_valid = 1'b1;
            case (counter)
               0:       resp_data = FLIT_WIDTH'(HOST_ID);
               1:       resp_data = FLIT_WIDTH'(MOD_ID);
               default: resp_data = {TYPE_EVENT, {(FLIT_WIDTH - 2){1'b0}}};
            endcase
            if (resp_ready) begin
               nxt_counter = counter + 1'b1;
               if (counter == PKT_CNT_W'(HDR_FLITS - 1)) begin
                  nxt_counter = '0;
                  nxt_state   = S_READ;
               end
            end
         end
         S_READ: begin
            resp_valid = read_valid;
            resp_data  = read_data[(WORD_FLITS - wcounter) * FLIT_WIDTH - 1 -: FLIT_WIDTH];
            resp_last  = (counter == PKT_CNT_W'(MAX_PKT_LEN - 1)) ||
                         (word_end && req_beats == BEAT_WIDTH'(1));
            if (read_valid && resp_ready) begin
               nxt_counter  = counter + 1'b1;
               nxt_wcounter = wcounter + 1'b1;
               if (word_end) begin
                  read_ready    = 1'b1;              // Word fully sent
                  nxt_wcounter  = '0;
                  nxt_req_beats = req_beats - 1'b1;
               end
               if (resp_last) begin
                  nxt_counter = '0;
                  nxt_state   = (word_end && req_beats == BEAT_WIDTH'(1)) ? S_HDR : S_RD_HDR;
               end
            end
         end
         default: nxt_state = S_HDR;
      endcase
   end

endmodule

/* source/mam_sram.sv */
`timescale 1ns/1ps

module mam_sram
   import mam_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  req_valid,
   input  logic                  req_rw,
   input  logic [ADDR_WIDTH-1:0] req_addr,
   input  logic                  req_burst,
   input  logic [BEAT_WIDTH-1:0] req_beats,
   output logic                  req_ready,
   input  logic                  write_valid,
   input  logic [DATA_WIDTH-1:0] write_data,
   input  logic [STRB_WIDTH-1:0] write_strb,
   output logic                  write_ready,
   output logic                  read_valid,
   output logic [DATA_WIDTH-1:0] read_data,
   input  logic                  read_ready
);

   typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ} mstate_t;

   mstate_t               state;
   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
   logic [ADDR_WIDTH-1:0] offset;
   logic [WORD_IDX_W-1:0] req_idx;
   logic [WORD_IDX_W-1:0] idx;
   logic [BEAT_WIDTH-1:0] beats;                     // Remaining beats
   logic                  beat_done;

   assign offset      = req_addr - BASE_ADDR0;
   assign req_idx     = offset[WORD_IDX_W+1:2];      // Wraps modulo memory size
   assign req_ready   = (state == M_IDLE);
   assign write_ready = (state == M_WRITE);
   assign beat_done   = (write_valid && write_ready) || (read_valid && read_ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= M_IDLE;
         read_valid <= 1'b0;
      end else if (req_valid && req_ready) begin
         state      <= req_rw ? M_WRITE : M_READ;
         read_valid <= !req_rw;
      end else if (beat_done && beats == BEAT_WIDTH'(1)) begin
         state      <= M_IDLE;
         read_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         idx       <= req_idx;
         beats     <= req_burst ? req_beats : BEAT_WIDTH'(1);
         read_data <= mem[req_idx];
      end else if (beat_done) begin
         idx       <= idx + 1'b1;
         beats     <= beats - 1'b1;
         read_data <= mem[idx + 1'b1];               // Prefetch next word
      end
      if (write_valid && write_ready) begin
         for (int b = 0; b < STRB_WIDTH; b++) begin
            if (write_strb[b]) mem[idx][b*8 +: 8] <= write_data[b*8 +: 8];
         end
      end
   end

endmodule

/* source/debug_mem_subsys.sv */
`timescale 1ns/1ps

module debug_mem_subsys
   import dii_pkg::*, mam_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [FLIT_WIDTH-1:0] debug_in_data,
   input  logic                  debug_in_last,
   input  logic                  debug_in_valid,
   output logic                  debug_in_ready,
   output logic [FLIT_WIDTH-1:0] debug_out_data,
   output logic                  debug_out_last,
   output logic                  debug_out_valid,
   input  logic                  debug_out_ready
);

   logic [FLIT_WIDTH:0]   fin_data;                  // Last above flit
   logic                  fin_valid, fin_ready;
   logic [FLIT_WIDTH-1:0] ev_data, resp_data;
   logic                  ev_last, ev_valid, ev_ready;
   logic                  resp_last, resp_valid, resp_ready;
   logic                  req_valid, req_rw, req_burst, req_ready;
   logic [ADDR_WIDTH-1:0] req_addr;
   logic [BEAT_WIDTH-1:0] req_beats;
   logic                  write_valid, write_ready;
   logic [DATA_WIDTH-1:0] write_data;
   logic [STRB_WIDTH-1:0] write_strb;
   logic [DATA_WIDTH-1:0] read_data, sram_rd_data;
   logic                  read_valid, read_ready, sram_rd_valid, sram_rd_ready;

   flit_fifo #(.payload_t(logic [FLIT_WIDTH:0]), .DEPTH(4)) in_fifo (
      .clk, .rst,
      .in_data({debug_in_last, debug_in_data}), .in_valid(debug_in_valid),
      .in_ready(debug_in_ready),
      .out_data(fin_data), .out_valid(fin_valid), .out_ready(fin_ready)
   );

   osd_regaccess u_regaccess (
      .*,
      .in_data(fin_data[FLIT_WIDTH-1:0]), .in_last(fin_data[FLIT_WIDTH]),
      .in_valid(fin_valid), .in_ready(fin_ready),
      .out_data(debug_out_data), .out_last(debug_out_last),
      .out_valid(debug_out_valid), .out_ready(debug_out_ready)
   );

   osd_mam u_mam (.*);

   mam_sram u_sram (
      .*,
      .read_valid(sram_rd_valid), .read_data(sram_rd_data), .read_ready(sram_rd_ready)
   );

   flit_fifo #(.payload_t(logic [DATA_WIDTH-1:0]), .DEPTH(4)) rd_fifo (
      .clk, .rst,
      .in_data(sram_rd_data), .in_valid(sram_rd_valid), .in_ready(sram_rd_ready),
      .out_data(read_data), .out_valid(read_valid), .out_ready(read_ready)
   );

endmodule

/* tb/debug_mem_subsys_chk.sv */
`timescale 1ns/1ps

module debug_mem_subsys_chk
   import mam_pkg::*;
(
   input logic                  clk,
   input logic                  rst,
   input logic                  req_valid,
   input logic                  req_ready,
   input logic                  write_valid,
   input logic                  write_ready,
   input logic [DATA_WIDTH-1:0] write_data,
   input logic                  resp_valid
);

   req_hold: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid)
      else $error("req_valid dropped before req_ready");

   wdata_stable: assert property (@(posedge clk) disable iff (rst)
      write_valid && !write_ready |=> $stable(write_data))
      else $error("write_data changed while waiting for write_ready");

   resp_known: assert property (@(posedge clk) disable iff (rst)
      !$isunknown(resp_valid))
      else $error("resp_valid is unknown after reset");

endmodule

bind osd_mam debug_mem_subsys_chk u_chk (.*);

/* tb/debug_mem_subsys_tb.sv */
`timescale 1ns/1ps

module debug_mem_subsys_tb
   import dii_pkg::*, mam_pkg::*;
();

   localparam int          TIMEOUT  = 200;            // Cycles per wait
   localparam logic [15:0] HOST_SRC = 16'h0012;       // Requester of register reads

   typedef enum logic [1:0] {OP_REG, OP_WR, OP_RD} op_t;

   typedef struct {
      op_t         op;
      logic [31:0] addr;                              // Register or byte address
      int          beats;                             // Burst when above 1
      logic [3:0]  strb;
      logic [15:0] exp;                               // Register value
      logic        err;
      logic        bp;                                // Random output back-pressure
   } step_t;

   logic        clk;
   logic        rst;
   logic [15:0] debug_in_data;
   logic        debug_in_last;
   logic        debug_in_valid;
   logic        debug_in_ready;
   logic [15:0] debug_out_data;
   logic        debug_out_last;
   logic        debug_out_valid;
   logic        debug_out_ready;
   logic        bp_on;

   step_t       steps [$];
   logic [31:0] ref_mem [MEM_WORDS];
   logic [16:0] expq [$];                             // Expected {last, data}
   logic [15:0] body [$];                             // Event body before packing

   debug_mem_subsys dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH at time %0t: %s = %h, expected %h",
                            $time, name, got, exp));
      end
   endtask

   function automatic int word_index(input logic [31:0] addr, input int beat);
      return (int'((addr - BASE_ADDR0) >> 2) + beat) % MEM_WORDS;
   endfunction

   function automatic logic [15:0] make_cmd(input logic rw, input step_t s);
      logic [15:0] cmd;
      cmd                = '0;
      cmd[CMD_RW_BIT]    = rw;
      cmd[CMD_BURST_BIT] = (s.beats > 1);
      if (s.beats > 1) cmd[BEAT_WIDTH-1:0] = BEAT_WIDTH'(s.beats);
      else cmd[3:0] = s.strb;                         // Strobe of a single access
      return cmd;
   endfunction

   task automatic send_flit(input logic [15:0] data, input logic last);
      int waited;
      waited = 0;
      if ($urandom % 4 == 0) begin                    // Idle gap on input
         debug_in_valid = 1'b0;
         @(posedge clk);
         #1;
      end
      debug_in_data  = data;
      debug_in_last  = last;
      debug_in_valid = 1'b1;
      @(negedge clk);
      while (!debug_in_ready) begin
         waited++;
         if (waited > TIMEOUT) fail_run("Input flit was never accepted by the DUT");
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      debug_in_valid = 1'b0;
   endtask

   task automatic send_packet(input logic [15:0] src, input logic [15:0] typ,
                              input int first, input int n);
      send_flit(16'(MOD_ID), 1'b0);
      send_flit(src, 1'b0);
      send_flit(typ, 1'b0);
      for (int i = first; i < first + n; i++) begin
         send_flit(body[i], i == first + n - 1);
      end
   endtask

   task automatic send_events();
      int pos;
      int n;
      pos = 0;
      while (pos < body.size()) begin
         n = (body.size() - pos > MAX_PKT_LEN) ? MAX_PKT_LEN : body.size() - pos;
         send_packet(16'(HOST_ID), {TYPE_EVENT, 14'h0}, pos, n);
         pos += n;
      end
   endtask

   task automatic recv_flit(output logic [15:0] data, output logic last);
      int   waited;
      logic got;
      waited = 0;
      got    = 1'b0;
      while (!got) begin
         debug_out_ready = bp_on ? 1'($urandom % 2) : 1'b1;
         @(negedge clk);
         if (debug_out_valid && debug_out_ready) begin
            got = 1'b1;
         end else begin
            waited++;
            if (waited > TIMEOUT) fail_run("No response flit arrived from the DUT");
            @(posedge clk);
            #1;
         end
      end
      data = debug_out_data;
      last = debug_out_last;
      @(posedge clk);
      #1;
      debug_out_ready = 1'b0;
   endtask

   task automatic check_response();
      logic [15:0] data;
      logic        last;
      int          k;
      k = 0;
      while (expq.size() > 0) begin
         recv_flit(data, last);
         check_value($sformatf("debug_out_data (flit %0d)", k), 32'(data),
                     32'(expq[0][15:0]));
         check_value($sformatf("debug_out_last (flit %0d)", k), 32'(last),
                     32'(expq[0][16]));
         void'(expq.pop_front());
         k++;
      end
   endtask

   task automatic do_reg(input step_t s);
      body.delete();
      body.push_back(s.addr[15:0]);
      send_packet(HOST_SRC, {TYPE_REG, SUB_REG_READ, 10'h000}, 0, 1);
      expq.push_back({1'b0, HOST_SRC});               // Back to requester
      expq.push_back({1'b0, 16'(MOD_ID)});
      expq.push_back({1'b0, TYPE_REG, s.err ? SUB_REG_ERR : SUB_REG_READ_RESP, 10'h000});
      expq.push_back({1'b1, s.exp});
      check_response();
   endtask

   task automatic do_write(input step_t s);
      logic [31:0] wdata;
      logic [3:0]  strb;
      int          w;
      body.delete();
      strb = (s.beats > 1) ? 4'hf : s.strb;
      body.push_back(make_cmd(1'b1, s));
      body.push_back(s.addr[31:16]);
      body.push_back(s.addr[15:0]);
      for (int b = 0; b < s.beats; b++) begin
         wdata = $urandom;
         w     = word_index(s.addr, b);
         for (int i = 0; i < 4; i++) begin
            if (strb[i]) ref_mem[w][i*8 +: 8] = wdata[i*8 +: 8];
         end
         body.push_back(wdata[31:16]);
         body.push_back(wdata[15:0]);
      end
      send_events();
   endtask

   task automatic do_read(input step_t s);
      logic [15:0] flits [$];
      int          n;
      body.delete();
      body.push_back(make_cmd(1'b0, s));
      body.push_back(s.addr[31:16]);
      body.push_back(s.addr[15:0]);
      send_events();
      for (int b = 0; b < s.beats; b++) begin
         flits.push_back(ref_mem[word_index(s.addr, b)][31:16]);
         flits.push_back(ref_mem[word_index(s.addr, b)][15:0]);
      end
      n = flits.size();
      for (int i = 0; i < n; i++) begin
         if (i % MAX_PKT_LEN == 0) begin              // New read packet header
            expq.push_back({1'b0, 16'(HOST_ID)});
            expq.push_back({1'b0, 16'(MOD_ID)});
            expq.push_back({1'b0, TYPE_EVENT, 14'h0});
         end
         expq.push_back({(i % MAX_PKT_LEN == MAX_PKT_LEN - 1) || (i == n - 1), flits[i]});
      end
      check_response();
   endtask

   task automatic load_table();
      steps.push_back(step_t'{OP_REG, 32'h0000, 1, 4'h0, MODID_VALUE, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0200, 1, 4'h0, 16'(DATA_WIDTH), 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0202, 1, 4'h0, 16'(REGIONS), 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0280, 1, 4'h0, BASE_ADDR0[15:0], 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0281, 1, 4'h0, BASE_ADDR0[31:16], 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0282, 1, 4'h0, 16'h0000, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0283, 1, 4'h0, 16'h0000, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0284, 1, 4'h0, 16'(MEM_SIZE0), 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0285, 1, 4'h0, 16'(MEM_SIZE0 >> 16), 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0286, 1, 4'h0, 16'h0000, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0287, 1, 4'h0, 16'h0000, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0123, 1, 4'h0, 16'h0000, 1'b1, 1'b0});  // Unmapped
      steps.push_back(step_t'{OP_WR, BASE_ADDR0 + 32'h10, 1, 4'hf, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_WR, BASE_ADDR0 + 32'h10, 1, 4'h5, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_WR, BASE_ADDR0 + 32'h14, 1, 4'hf, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_WR, BASE_ADDR0 + 32'h14, 1, 4'ha, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_WR, BASE_ADDR0 + 32'h14, 1, 4'h1, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_RD, BASE_ADDR0 + 32'h10, 1, 4'h0, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_RD, BASE_ADDR0 + 32'h14, 1, 4'h0, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_WR, BASE_ADDR0 + 32'h100, 10, 4'h0, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_RD, BASE_ADDR0 + 32'h100, 10, 4'h0, 16'h0, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_RD, BASE_ADDR0 + 32'h100, 10, 4'h0, 16'h0, 1'b0, 1'b1});
      steps.push_back(step_t'{OP_REG, 32'h0001, 1, 4'h0, MODVERSION_VALUE, 1'b0, 1'b0});
      steps.push_back(step_t'{OP_REG, 32'h0201, 1, 4'h0, 16'(ADDR_WIDTH), 1'b0, 1'b1});
   endtask

   initial begin
      void'($urandom(32'hf4637d81));
      rst             = 1'b1;
      debug_in_data   = '0;
      debug_in_last   = 1'b0;
      debug_in_valid  = 1'b0;
      debug_out_ready = 1'b0;
      bp_on           = 1'b0;
      load_table();
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      check_value("debug_out_valid", 32'(debug_out_valid), 32'h0);
      foreach (steps[i]) begin
         bp_on = steps[i].bp;
         case (steps[i].op)
            OP_REG:  do_reg(steps[i]);
            OP_WR:   do_write(steps[i]);
            default: do_read(steps[i]);
         endcase
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* debug_mem_subsys.f */
source/dii_pkg.sv
source/mam_pkg.sv
source/flit_fifo.sv
source/osd_regaccess.sv
source/osd_mam.sv
source/mam_sram.sv
source/debug_mem_subsys.sv
tb/debug_mem_subsys_chk.sv
tb/debug_mem_subsys_tb.sv

/* Makefile */
SIM       = verilator
TOP       = debug_mem_subsys_tb
FILELIST  = debug_mem_subsys.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP)

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
